/* Bender.yml */
package:
  name: rf16x160

sources:
  - include_dirs:
      - .
    files:
      - rf_pkg.sv
      - rf_write_if.sv
      - rf_write_stage.sv
      - rf_read_stage.sv
      - rf_array.sv
      - rf16x160.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rf16x160.sv

/* rf16x160.sv */
/*
 * 16 x 160 register file, one read port and one write port.
 * Write stage and read stage run side by side and meet at the array.
 * hold freezes both request registers; reset_l clears dout and valids.
 */

`timescale 1ns/1ns

module rf16x160
	import rf_pkg::*;
(
	input  logic        clk,
	input  logic        reset_l,
	input  logic        hold,
	input  logic        wr_en,
	input  rf_addr_t    wr_adr,
	input  rf_data_t    din,
	input  rf_word_en_t word_wen,
	input  rf_byte_en_t byte_wen,
	input  logic        read_en,
	input  rf_addr_t    rd_adr,
	output rf_data_t    dout
);

	// staged write request into the array
	rf_write_if wr_bus ();

	// registered read address and the entry it selects
	rf_addr_t rd_addr_q;
	rf_data_t rd_word;

	////////////////////
	// write side
	////////////////////

	rf_write_stage i_write_stage
	(
		.clk      (clk),
		.reset_l  (reset_l),
		.hold     (hold),
		.wr_en    (wr_en),
		.wr_adr   (wr_adr),
		.din      (din),
		.word_wen (word_wen),
		.byte_wen (byte_wen),
		.wr       (wr_bus.stage)
	);

	////////////////////
	// read side
	////////////////////

	rf_read_stage i_read_stage
	(
		.clk       (clk),
		.reset_l   (reset_l),
		.hold      (hold),
		.read_en   (read_en),
		.rd_adr    (rd_adr),
		.rd_addr_q (rd_addr_q),
		.rd_word   (rd_word),
		.dout      (dout)
	);

	////////////////////
	// storage
	////////////////////

	// no reset here, contents are undefined until written
	rf_array i_array
	(
		.clk     (clk),
		.wr      (wr_bus.array),
		.rd_addr (rd_addr_q),
		.rd_word (rd_word)
	);

endmodule

/* rf_array.sv */
/*
 * Storage of the register file, 16 entries of 160 bits.
 * Bit-masked write on the rising edge, combinational read.
 * A read of the entry being written sees the old contents.
 */

`timescale 1ns/1ns

module rf_array
	import rf_pkg::*;
(
	input  logic      clk,
	rf_write_if.array wr,
	input  rf_addr_t  rd_addr,
	output rf_data_t  rd_word
);

	// one entry per address value
	rf_data_t mem [2**$bits(rf_addr_t)];

	////////////////////
	// write port
	////////////////////

	// only bits under the mask change, the rest keep their value
	always_ff @(posedge clk)
	begin
		if (wr.valid)
			mem[wr.addr] <= (mem[wr.addr] & ~wr.mask) | (wr.data & wr.mask);
	end

	////////////////////
	// read port
	////////////////////

	// the write above is non-blocking, so a same-edge read gets old data
	assign rd_word = mem[rd_addr];

	////////////////////
	// checks
	////////////////////

	a_wr_addr_known: assert property (@(posedge clk)
		wr.valid |-> !$isunknown(wr.addr));

endmodule

/* rf_macros.svh */
/*
 * Size constants for the 16 x 160 register file.
 * Included by the type package and the testbench, which build
 * their widths from these values.
 */

`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

////////////////////
// array geometry
////////////////////

// number of entries
`define RF_DEPTH 16

// entry address width, log2 of the depth
`define RF_ADDR_W 4

// bits per entry
`define RF_WIDTH 160

////////////////////
// write enables
////////////////////

// word lanes interleave bit by bit, lane = bit mod 4
`define RF_WORD_LANES 4

// one enable per 8 bits of the entry
`define RF_BYTES 20

`endif

/* rf_pkg.sv */
/*
 * Types shared by the register file modules and the testbench.
 * Import with rf_pkg::* in the module header.
 */

`include "rf_macros.svh"

package rf_pkg;

	////////////////////
	// request fields
	////////////////////

	// entry address
	typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

	// one entry, also used as the per-bit write mask
	typedef logic [`RF_WIDTH-1:0] rf_data_t;

	// word lane enables, lane i covers bits i, i+4, i+8 ...
	typedef logic [`RF_WORD_LANES-1:0] rf_word_en_t;

	// byte enables, byte j covers bits 8j to 8j+7
	typedef logic [`RF_BYTES-1:0] rf_byte_en_t;

endpackage

/* rf_read_stage.sv */
/*
 * Read request register and output register of the register file.
 * The address is registered on the first edge and the entry is
 * captured into dout on the second. dout holds when no read issues.
 */

`timescale 1ns/1ns

module rf_read_stage
	import rf_pkg::*;
(
	input  logic     clk,
	input  logic     reset_l,
	input  logic     hold,
	input  logic     read_en,
	input  rf_addr_t rd_adr,
	output rf_addr_t rd_addr_q,
	input  rf_data_t rd_word,
	output rf_data_t dout
);

	logic rd_en_q;

	// request valid flag and output register
	always_ff @(posedge clk)
	begin
		if (reset_l)
		begin
			rd_en_q <= 1'b0;
			dout    <= '0;
		end
		else if (!hold)
		begin
			rd_en_q <= read_en;
			// rd_word is the entry before any write landing on this edge
			if (rd_en_q)
				dout <= rd_word;
		end
	end

	// address register, kept while hold is high
	always_ff @(posedge clk)
	begin
		if (!hold)
			rd_addr_q <= rd_adr;
	end

	// capture must index a known entry
	a_rd_addr_known: assert property (@(posedge clk) disable iff (reset_l)
		(rd_en_q && !hold) |-> !$isunknown(rd_addr_q));

endmodule

/* rf_write_if.sv */
/*
 * Staged write request from the write stage into the storage array.
 * The array stores data at every bit where mask is set, on each
 * rising edge with valid high. There is no back-pressure.
 */

`timescale 1ns/1ns

interface rf_write_if
	import rf_pkg::*;
();

	// request issues this cycle
	logic     valid;

	// target entry
	rf_addr_t addr;

	// new contents, only bits under mask are used
	rf_data_t data;

	// per-bit write enable, expanded from word and byte enables
	rf_data_t mask;

	modport stage
	(
		output valid,
		output addr,
		output data,
		output mask
	);

	modport array
	(
		input valid,
		input addr,
		input data,
		input mask
	);

endinterface

/* rf_write_stage.sv */
/*
 * Write request register of the register file.
 * Captures one request per cycle, freezes it while hold is high and
 * presents it to the array one cycle later with a 160-bit bit mask.
 */

`timescale 1ns/1ns

module rf_write_stage
	import rf_pkg::*;
(
	input  logic        clk,
	input  logic        reset_l,
	input  logic        hold,
	input  logic        wr_en,
	input  rf_addr_t    wr_adr,
	input  rf_data_t    din,
	input  rf_word_en_t word_wen,
	input  rf_byte_en_t byte_wen,
	rf_write_if.stage   wr
);

	logic        wr_en_q;
	rf_addr_t    wr_adr_q;
	rf_data_t    din_q;
	rf_word_en_t word_wen_q;
	rf_byte_en_t byte_wen_q;

	////////////////////
	// request register
	////////////////////

	// the valid flag is the only state that reset touches
	always_ff @(posedge clk)
	begin
		if (reset_l)
			wr_en_q <= 1'b0;
		else if (!hold)
			wr_en_q <= wr_en;
	end

	always_ff @(posedge clk)
	begin
		if (!hold)
		begin
			wr_adr_q   <= wr_adr;
			din_q      <= din;
			word_wen_q <= word_wen;
			byte_wen_q <= byte_wen;
		end
	end

	////////////////////
	// mask expansion
	////////////////////

	// bit i needs its word lane (i mod 4) and its byte (i div 8)
	always_comb
	begin
		for (int i = 0; i < $bits(rf_data_t); i++)
			wr.mask[i] = word_wen_q[i % $bits(rf_word_en_t)] & byte_wen_q[i / 8];
	end

	// a held request stays parked and issues once hold drops
	assign wr.valid = wr_en_q & ~hold;
	assign wr.addr  = wr_adr_q;
	assign wr.data  = din_q;

	// a request that gets captured must carry known enables
	a_wen_known: assert property (@(posedge clk) disable iff (reset_l)
		(wr_en && !hold) |-> !$isunknown({word_wen, byte_wen}));

endmodule

/* tb_rf16x160.sv */
/*
 * Self-checking testbench for the 16 x 160 register file.
 * A reference model follows the request pipeline and concurrent
 * assertions compare dout with it on every rising edge.
 */

`timescale 1ns/1ns

`include "rf_macros.svh"

module tb_rf16x160
	import rf_pkg::*;
();

	// stimulus length per phase, in cycles
	localparam int RAND_ITERS     = 400;
	localparam int FULL_CYCLES    = 2 * `RF_DEPTH + 8;
	localparam int COLLIDE_CYCLES = 3 * `RF_DEPTH;
	localparam int HOLD_CYCLES    = 10 * `RF_DEPTH;
	localparam int STIM_CYCLES    = 8 + FULL_CYCLES + RAND_ITERS + COLLIDE_CYCLES + HOLD_CYCLES;
	localparam int TIMEOUT        = 2 * STIM_CYCLES;

	logic        clk = 1'b0;
	logic        reset_l;
	logic        hold;
	logic        wr_en;
	rf_addr_t    wr_adr;
	rf_data_t    din;
	rf_word_en_t word_wen;
	rf_byte_en_t byte_wen;
	logic        read_en;
	rf_addr_t    rd_adr;
	rf_data_t    dout;

	integer seed;
	int     cycles    = 0;
	int     n_reads   = 0;
	int     n_collide = 0;
	int     n_parked  = 0;

	// reference model state
	rf_data_t    model_mem [`RF_DEPTH];
	rf_data_t    exp_dout;
	logic        pend_wr_v;
	rf_addr_t    pend_wr_addr;
	rf_data_t    pend_wr_data;
	rf_word_en_t pend_ww;
	rf_byte_en_t pend_bw;
	logic        pend_rd_v;
	rf_addr_t    pend_rd_addr;

	rf16x160 i_dut
	(
		.clk      (clk),
		.reset_l  (reset_l),
		.hold     (hold),
		.wr_en    (wr_en),
		.wr_adr   (wr_adr),
		.din      (din),
		.word_wen (word_wen),
		.byte_wen (byte_wen),
		.read_en  (read_en),
		.rd_adr   (rd_adr),
		.dout     (dout)
	);

	always #2 clk = ~clk;

	////////////////////
	// reference model
	////////////////////

	// bit b changes when byte b/8 and word lane b%4 are both enabled
	function automatic rf_data_t merge_bits(input rf_data_t old_v, input rf_data_t new_v,
		input rf_word_en_t ww, input rf_byte_en_t bw);
		rf_data_t r;
		r = old_v;
		for (int j = 0; j < `RF_BYTES; j++)
		begin
			for (int k = 0; k < 8; k++)
			begin
				if (bw[j] && ww[(8 * j + k) % `RF_WORD_LANES])
					r[8 * j + k] = new_v[8 * j + k];
			end
		end
		return r;
	endfunction

	// read takes the entry before this edge's write lands
	always @(posedge clk)
	begin
		if (reset_l)
		begin
			pend_wr_v <= 1'b0;
			pend_rd_v <= 1'b0;
			exp_dout  <= '0;
		end
		else if (hold)
		begin
			if (pend_wr_v || pend_rd_v)
				n_parked <= n_parked + 1;
		end
		else
		begin
			if (pend_rd_v)
			begin
				exp_dout <= model_mem[pend_rd_addr];
				n_reads  <= n_reads + 1;
			end
			if (pend_wr_v)
				model_mem[pend_wr_addr] <= merge_bits(model_mem[pend_wr_addr], pend_wr_data,
					pend_ww, pend_bw);
			if (pend_rd_v && pend_wr_v && pend_rd_addr == pend_wr_addr)
				n_collide <= n_collide + 1;
			pend_wr_v    <= wr_en;
			pend_wr_addr <= wr_adr;
			pend_wr_data <= din;
			pend_ww      <= word_wen;
			pend_bw      <= byte_wen;
			pend_rd_v    <= read_en;
			pend_rd_addr <= rd_adr;
		end
	end

	////////////////////
	// checks
	////////////////////

	a_dout_match: assert property (@(posedge clk) disable iff (reset_l) dout === exp_dout)
	else
	begin
		$display("ERR %0t dout expected %h got %h", $time, $sampled(exp_dout), $sampled(dout));
		$display("Regression failed");
		$fatal(1);
	end

	a_reset_clears: assert property (@(posedge clk) $fell(reset_l) |-> dout === '0)
	else
	begin
		$display("ERR %0t dout expected %h got %h", $time, {`RF_WIDTH{1'b0}}, $sampled(dout));
		$display("Regression failed");
		$fatal(1);
	end

	a_hold_freezes: assert property (@(posedge clk) disable iff (reset_l) hold |=> $stable(dout))
	else
	begin
		$display("dout changed at %0t although hold was high on the edge before", $time);
		$display("Regression failed");
		$fatal(1);
	end

	// run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT)
		begin
			$display("run did not finish within %0d cycles", TIMEOUT);
			$display("Regression failed");
			$fatal(1);
		end
	end

	////////////////////
	// stimulus helpers
	////////////////////

	function automatic rf_data_t rand_data();
		rf_data_t d;
		for (int k = 0; k < `RF_WIDTH / 32; k++)
			d[32 * k +: 32] = $random(seed);
		return d;
	endfunction

	function automatic rf_addr_t rand_addr();
		logic [31:0] r;
		r = $random(seed);
		return r[`RF_ADDR_W-1:0];
	endfunction

	// one cycle of inputs, driven on the falling edge
	task automatic apply_cycle(input logic w, input rf_addr_t wa, input rf_data_t d,
		input rf_word_en_t ww, input rf_byte_en_t bw, input logic r, input rf_addr_t ra,
		input logic h);
		@(negedge clk);
		wr_en    = w;
		wr_adr   = wa;
		din      = d;
		word_wen = ww;
		byte_wen = bw;
		read_en  = r;
		rd_adr   = ra;
		hold     = h;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
			apply_cycle(1'b0, '0, '0, '0, '0, 1'b0, '0, 1'b0);
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial
	begin
		rf_addr_t    a;
		rf_word_en_t ww;
		rf_byte_en_t bw;
		logic [31:0] r;

		seed     = 32'h89be7309;
		reset_l  = 1'b1;
		hold     = 1'b0;
		wr_en    = 1'b0;
		wr_adr   = '0;
		din      = '0;
		word_wen = '0;
		byte_wen = '0;
		read_en  = 1'b0;
		rd_adr   = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset_l = 1'b0;

		// full writes to every entry, then read them back
		for (int i = 0; i < `RF_DEPTH; i++)
			apply_cycle(1'b1, i, rand_data(), '1, '1, 1'b0, '0, 1'b0);
		for (int i = 0; i < `RF_DEPTH; i++)
			apply_cycle(1'b0, '0, '0, '0, '0, 1'b1, i, 1'b0);
		idle_cycles(3);

		// partial writes with random lanes and bytes, reads alongside
		for (int i = 0; i < RAND_ITERS; i++)
		begin
			r  = $random(seed);
			ww = r[`RF_WORD_LANES-1:0];
			r  = $random(seed);
			bw = r[`RF_BYTES-1:0];
			apply_cycle(1'b1, rand_addr(), rand_data(), ww, bw, 1'b1, rand_addr(), 1'b0);
		end
		idle_cycles(2);

		// read and write of one entry on the same edge, then a second read
		for (int i = 0; i < `RF_DEPTH; i++)
		begin
			apply_cycle(1'b1, i, rand_data(), '1, '1, 1'b1, i, 1'b0);
			apply_cycle(1'b0, '0, '0, '0, '0, 1'b1, i, 1'b0);
			idle_cycles(1);
		end

		// park a write and a read under hold while the inputs keep moving
		for (int i = 0; i < `RF_DEPTH; i++)
		begin
			a  = i;
			r  = $random(seed);
			ww = r[`RF_WORD_LANES-1:0];
			bw = r[`RF_WORD_LANES +: `RF_BYTES];
			apply_cycle(1'b1, a, rand_data(), ww, bw, 1'b1, a, 1'b0);
			repeat (1 + (i % 4))
				apply_cycle(1'b1, rand_addr(), rand_data(), '1, '1, 1'b1, rand_addr(), 1'b1);
			apply_cycle(1'b0, '0, '0, '0, '0, 1'b0, '0, 1'b0);
			apply_cycle(1'b0, '0, '0, '0, '0, 1'b1, a, 1'b0);
			idle_cycles(2);
		end
		idle_cycles(4);

		if (n_reads == 0 || n_collide == 0 || n_parked == 0)
		begin
			$display("stimulus never reached a read, a collision or a held request");
			$display("Regression failed");
			$fatal(1);
		end
		else
		begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+.
rf_pkg.sv
rf_write_if.sv
rf_write_stage.sv
rf_read_stage.sv
rf_array.sv
rf16x160.sv
tb_rf16x160.sv
